//--- Bender.yml
package:
  name: rob_subsystem

dependencies: {}

sources:
  # Package first, then leaf modules, then the top level
  - hdl/rob_pkg.sv
  - hdl/tag_cam.sv
  - hdl/reorder_buffer.sv
  - hdl/retire_port.sv
  - hdl/rob_subsystem.sv

  - target: test
    files:
      - test/tb_rob_subsystem.sv

//--- hdl/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer import rob_pkg::*; (
	input  logic                           clock,
	input  logic                           rst_n,
	input  logic                           flush,
	input  dispatch_slot_t [SS_WIDTH-1:0]  dispatch,
	input  cdb_slot_t [SS_WIDTH-1:0]       cdb,
	input  logic [SLOT_CNT_W-1:0]          retire_limit,
	output retire_slot_t [SS_WIDTH-1:0]    retire_rows,
	output logic [SLOT_CNT_W-1:0]          dispatch_credits
);

	// Row payload, only written at dispatch
	typedef struct packed {
		logic [PHYS_TAG_W-1:0] t_new;
		logic [PHYS_TAG_W-1:0] t_old;
		logic [ARCH_REG_W-1:0] arch_dest;
		rob_op_e               op;
	} rob_row_t;

	rob_row_t [ROB_DEPTH-1:0] rows;
	logic [ROB_DEPTH-1:0]     busy;
	logic [ROB_DEPTH-1:0]     ready;
	logic [ROB_IDX_W-1:0]     head;   // Oldest row
	logic [ROB_IDX_W-1:0]     tail;   // Next free row

	logic [ROB_DEPTH-1:0][PHYS_TAG_W-1:0] entry_tags;
	logic [ROB_DEPTH-1:0]                 hits;
	logic [ROB_DEPTH-1:0]                 can_retire;

	logic [SS_WIDTH-1:0][ROB_IDX_W-1:0] ret_idx;
	logic [SS_WIDTH-1:0]                ret_go;
	logic [SLOT_CNT_W-1:0]              ret_count;
	logic [SS_WIDTH-1:0][ROB_IDX_W-1:0] disp_idx;
	logic [SLOT_CNT_W-1:0]              disp_count;

	// Completion matching
	always_comb begin
		for (int i = 0; i < ROB_DEPTH; i++) begin
			entry_tags[i] = rows[i].t_new;
		end
	end

	tag_cam tag_cam_i (
		.entry_tags (entry_tags),
		.cdb        (cdb),
		.hits       (hits)
	);

	// A broadcast in this cycle already counts as ready
	assign can_retire = busy & (ready | hits);

	// Walk from the head, stop at the first row that cannot go
	always_comb begin
		logic in_order;
		in_order  = !flush;   // Nothing retires during a flush
		ret_count = '0;
		for (int k = 0; k < SS_WIDTH; k++) begin
			ret_idx[k] = head + ROB_IDX_W'(k);
			in_order   = in_order && (SLOT_CNT_W'(k) < retire_limit)
				&& can_retire[ret_idx[k]];
			ret_go[k]  = in_order;
			ret_count  = ret_count + SLOT_CNT_W'(in_order);
		end
	end

	always_comb begin
		for (int k = 0; k < SS_WIDTH; k++) begin
			retire_rows[k].valid     = ret_go[k];
			retire_rows[k].t_new     = rows[ret_idx[k]].t_new;
			retire_rows[k].t_old     = rows[ret_idx[k]].t_old;
			retire_rows[k].arch_dest = rows[ret_idx[k]].arch_dest;
			retire_rows[k].op        = rows[ret_idx[k]].op;
		end
	end

	// Every freed row hands one credit back to the dispatcher
	assign dispatch_credits = ret_count;

	// Valid slots arrive packed from slot 0, so slot s lands at tail + s
	always_comb begin
		disp_count = '0;
		for (int s = 0; s < SS_WIDTH; s++) begin
			disp_idx[s] = tail + ROB_IDX_W'(s);
			disp_count  = disp_count + SLOT_CNT_W'(dispatch[s].valid);
		end
	end

	// Control state
	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			busy  <= '0;
			ready <= '0;
			head  <= '0;
			tail  <= '0;
		end else begin
			for (int i = 0; i < ROB_DEPTH; i++) begin
				if (busy[i] && hits[i]) begin
					ready[i] <= 1'b1;
				end
			end

			// Retired rows become free
			for (int k = 0; k < SS_WIDTH; k++) begin
				if (ret_go[k]) begin
					busy[ret_idx[k]]  <= 1'b0;
					ready[ret_idx[k]] <= 1'b0;
				end
			end

			for (int s = 0; s < SS_WIDTH; s++) begin
				if (dispatch[s].valid) begin
					busy[disp_idx[s]]  <= 1'b1;
					ready[disp_idx[s]] <= !op_writes_reg(dispatch[s].op);  // No wait for stores etc
				end
			end

			head <= head + ROB_IDX_W'(ret_count);
			tail <= tail + ROB_IDX_W'(disp_count);
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		for (int s = 0; s < SS_WIDTH; s++) begin
			if (dispatch[s].valid) begin
				rows[disp_idx[s]].t_new     <= dispatch[s].t_new;
				rows[disp_idx[s]].t_old     <= dispatch[s].t_old;
				rows[disp_idx[s]].arch_dest <= dispatch[s].arch_dest;
				rows[disp_idx[s]].op        <= dispatch[s].op;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/retire_port.sv
`timescale 1ns/100ps
`default_nettype none

module retire_port import rob_pkg::*; (
	input  logic                          clock,
	input  logic                          rst_n,
	input  retire_slot_t [SS_WIDTH-1:0]   retire_rows,
	input  logic                          commit_credit,
	output logic [SLOT_CNT_W-1:0]         retire_limit,
	output retire_slot_t [SS_WIDTH-1:0]   retired
);

	logic [CREDIT_W-1:0]         credits;   // Commit credits held
	logic [SLOT_CNT_W-1:0]       spent;
	logic [SS_WIDTH-1:0]         valid_q;
	retire_slot_t [SS_WIDTH-1:0] rows_q;

	// One credit per row leaving the table this cycle
	always_comb begin
		spent = '0;
		for (int k = 0; k < SS_WIDTH; k++) begin
			spent = spent + SLOT_CNT_W'(retire_rows[k].valid);
		end
	end

	// Never let more rows go than commit can take
	assign retire_limit = (credits >= CREDIT_W'(SS_WIDTH)) ? SLOT_CNT_W'(SS_WIDTH)
		: SLOT_CNT_W'(credits);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			credits <= CREDIT_W'(COMMIT_CREDITS);
		end else begin
			// Returns come back one per pulse
			credits <= credits - CREDIT_W'(spent) + CREDIT_W'(commit_credit);
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			for (int k = 0; k < SS_WIDTH; k++) begin
				valid_q[k] <= retire_rows[k].valid;
			end
		end
	end

	always_ff @(posedge clock) begin
		rows_q <= retire_rows;
	end

	// Registered pair toward commit
	always_comb begin
		retired = rows_q;
		for (int k = 0; k < SS_WIDTH; k++) begin
			retired[k].valid = valid_q[k];
		end
	end

endmodule

`default_nettype wire

//--- hdl/rob_pkg.sv
`default_nettype none

package rob_pkg;

	// Machine sizes
	localparam int SS_WIDTH       = 2;    // Dispatch, completion and retire slots
	localparam int ROB_DEPTH      = 8;
	localparam int ROB_IDX_W      = $clog2(ROB_DEPTH);
	localparam int PHYS_TAG_W     = 6;    // 64 physical registers
	localparam int ARCH_REG_W     = 5;
	localparam int COMMIT_CREDITS = 4;

	// Counts of 0..SS_WIDTH slots per cycle
	localparam int SLOT_CNT_W = $clog2(SS_WIDTH + 1);
	localparam int CREDIT_W   = $clog2(COMMIT_CREDITS + 1);

	typedef enum logic [2:0] {
		OP_ALU    = 3'd0,
		OP_LOAD   = 3'd1,
		OP_STORE  = 3'd2,
		OP_BRANCH = 3'd3,
		OP_HALT   = 3'd4
	} rob_op_e;

	// One dispatch lane
	typedef struct packed {
		logic                  valid;
		logic [PHYS_TAG_W-1:0] t_new;      // Tag taken from the free list
		logic [PHYS_TAG_W-1:0] t_old;      // Previous mapping, freed at commit
		logic [ARCH_REG_W-1:0] arch_dest;
		rob_op_e               op;
	} dispatch_slot_t;

	// One completion broadcast
	typedef struct packed {
		logic                  valid;
		logic [PHYS_TAG_W-1:0] tag;
	} cdb_slot_t;

	// One retiring row toward commit
	typedef struct packed {
		logic                  valid;
		logic [PHYS_TAG_W-1:0] t_new;
		logic [PHYS_TAG_W-1:0] t_old;
		logic [ARCH_REG_W-1:0] arch_dest;
		rob_op_e               op;
	} retire_slot_t;

	// Stores, branches and halt have no destination register
	// and so never wait for a completion broadcast
	function automatic logic op_writes_reg(input rob_op_e op);
		logic writes;
		case (op)
			OP_ALU,
			OP_LOAD: writes = 1'b1;
			default: writes = 1'b0;
		endcase
		return writes;
	endfunction

endpackage

`default_nettype wire

//--- hdl/rob_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module rob_subsystem import rob_pkg::*; (
	input  logic                           clock,
	input  logic                           rst_n,
	input  dispatch_slot_t [SS_WIDTH-1:0]  dispatch,
	input  cdb_slot_t [SS_WIDTH-1:0]       cdb,
	input  logic                           flush,          // Mispredict recovery
	input  logic                           commit_credit,  // One credit per pulse
	output retire_slot_t [SS_WIDTH-1:0]    retired,
	output logic [SLOT_CNT_W-1:0]          dispatch_credits
);

	// Retire port back to the table
	logic [SLOT_CNT_W-1:0] retire_limit;

	// Combinational head rows toward the retire register
	retire_slot_t [SS_WIDTH-1:0] retire_rows;

	reorder_buffer reorder_buffer_i (
		.clock            (clock),
		.rst_n            (rst_n),
		.flush            (flush),
		.dispatch         (dispatch),
		.cdb              (cdb),
		.retire_limit     (retire_limit),
		.retire_rows      (retire_rows),
		.dispatch_credits (dispatch_credits)
	);

	retire_port retire_port_i (
		.clock         (clock),
		.rst_n         (rst_n),
		.retire_rows   (retire_rows),
		.commit_credit (commit_credit),
		.retire_limit  (retire_limit),
		.retired       (retired)
	);

endmodule

`default_nettype wire

//--- hdl/tag_cam.sv
`timescale 1ns/100ps
`default_nettype none

// Fully combinational so a broadcast can retire its row in the same cycle
module tag_cam import rob_pkg::*; (
	input  logic [ROB_DEPTH-1:0][PHYS_TAG_W-1:0] entry_tags,
	input  cdb_slot_t [SS_WIDTH-1:0]             cdb,
	output logic [ROB_DEPTH-1:0]                 hits
);

	// One compare per entry and per broadcast lane
	logic [ROB_DEPTH-1:0][SS_WIDTH-1:0] match;

	always_comb begin
		for (int i = 0; i < ROB_DEPTH; i++) begin
			for (int j = 0; j < SS_WIDTH; j++) begin
				match[i][j] = cdb[j].valid && (cdb[j].tag == entry_tags[i]);
			end
		end
	end

	// Any lane marks the entry
	always_comb begin
		for (int i = 0; i < ROB_DEPTH; i++) begin
			hits[i] = |match[i];
		end
	end

endmodule

`default_nettype wire

//--- rob_subsystem.f
hdl/rob_pkg.sv
hdl/tag_cam.sv
hdl/reorder_buffer.sv
hdl/retire_port.sv
hdl/rob_subsystem.sv
test/tb_rob_subsystem.sv

//--- test/tb_rob_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rob_subsystem import rob_pkg::*; ();

	localparam int CLOCK_PERIOD  = 20;
	localparam int RESET_CYCLES  = 8;
	localparam int RANDOM_CYCLES = 300;
	localparam int AFTER_FLUSH   = 150;
	// Reset 8, directed about 80, random 450, drains about 100
	localparam int TEST_CYCLES    = 1000;
	localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

	logic                          clock;
	logic                          rst_n;
	dispatch_slot_t [SS_WIDTH-1:0] dispatch;
	cdb_slot_t [SS_WIDTH-1:0]      cdb;
	logic                          flush;
	logic                          commit_credit;
	retire_slot_t [SS_WIDTH-1:0]   retired;
	logic [SLOT_CNT_W-1:0]         dispatch_credits;

	// Reference model and credit bookkeeping
	dispatch_slot_t        exp_q[$];      // Program order
	logic [PHYS_TAG_W-1:0] pending[$];    // Tags not yet broadcast
	logic [PHYS_TAG_W-1:0] stale[$];
	logic [PHYS_TAG_W-1:0] next_tag = '0;
	logic [31:0]           lcg_state = 32'h4b1d;
	int                    disp_credits = ROB_DEPTH;
	int                    commit_held = 0;    // Held by the downstream model
	int                    credit_sum = 0;
	int                    retired_count = 0;
	int                    last_retire_cycle = 0;
	int                    cycle = 0;
	int                    return_gap = 0;
	bit                    return_enable = 1'b1;
	string                 test_name = "reset";

	rob_subsystem rob_subsystem_i (
		.clock            (clock),
		.rst_n            (rst_n),
		.dispatch         (dispatch),
		.cdb              (cdb),
		.flush            (flush),
		.commit_credit    (commit_credit),
		.retired          (retired),
		.dispatch_credits (dispatch_credits)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped at cycle %0d", cycle);
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected !== actual) begin
			fail_run($sformatf("Mismatch in test %s, %s: expected %0d, actual %0d",
				test_name, what, expected, actual));
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int bound);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[30:8] % bound);   // Low bits of an LCG repeat quickly
	endfunction

	function automatic rob_op_e random_op();
		int r;
		r = rand_below(8);
		case (r)
			0, 1, 2: return OP_ALU;
			3, 4:    return OP_LOAD;
			5:       return OP_STORE;
			6:       return OP_BRANCH;
			default: return OP_HALT;
		endcase
	endfunction

	function automatic void push_expected(input dispatch_slot_t slot);
		exp_q.push_back(slot);
	endfunction

	// Oldest dispatched entry is the next one to commit
	function automatic retire_slot_t expected_retire();
		dispatch_slot_t oldest;
		retire_slot_t   row;
		oldest = exp_q.pop_front();
		row.valid     = 1'b1;
		row.t_new     = oldest.t_new;
		row.t_old     = oldest.t_old;
		row.arch_dest = oldest.arch_dest;
		row.op        = oldest.op;
		return row;
	endfunction

	// disp_n < 0 picks a random width, force_op < 0 a random opcode
	task automatic run_cycle(input int disp_n, input int force_op, input bit do_cdb,
		input bit do_flush);
		dispatch_slot_t [SS_WIDTH-1:0] slots;
		cdb_slot_t [SS_WIDTH-1:0]      bcast;
		int                            n;
		int                            pick;
		@(posedge clock);
		#2;
		slots = '0;
		bcast = '0;
		if (do_flush) begin
			pending.delete();
			disp_credits = ROB_DEPTH;
		end else begin
			// Only tags already in the table complete
			if (do_cdb) begin
				for (int j = 0; j < SS_WIDTH; j++) begin
					if (pending.size() > 0 && rand_below(4) != 0) begin
						pick = rand_below(pending.size());
						bcast[j].valid = 1'b1;
						bcast[j].tag   = pending[pick];
						pending.delete(pick);
					end
				end
			end
			n = (disp_credits < SS_WIDTH) ? disp_credits : SS_WIDTH;
			if (disp_n < 0) begin
				n = rand_below(n + 1);
			end else if (disp_n < n) begin
				n = disp_n;
			end
			for (int s = 0; s < n; s++) begin
				slots[s].valid     = 1'b1;
				slots[s].t_new     = next_tag;
				slots[s].t_old     = PHYS_TAG_W'(rand_below(1 << PHYS_TAG_W));
				slots[s].arch_dest = ARCH_REG_W'(rand_below(1 << ARCH_REG_W));
				slots[s].op        = (force_op >= 0) ? rob_op_e'(force_op) : random_op();
				next_tag = next_tag + 1'b1;   // Rotation keeps in-flight tags unique
				push_expected(slots[s]);
				if (op_writes_reg(slots[s].op)) begin
					pending.push_back(slots[s].t_new);
				end
			end
			disp_credits = disp_credits - n;
		end
		// Downstream hands credits back one pulse at a time
		commit_credit = 1'b0;
		if (return_enable && commit_held > 0) begin
			if (return_gap == 0) begin
				commit_credit = 1'b1;
				commit_held   = commit_held - 1;
				return_gap    = rand_below(3);
			end else begin
				return_gap = return_gap - 1;
			end
		end
		dispatch = slots;
		cdb      = bcast;
		flush    = do_flush;
	endtask

	task automatic drain();
		return_enable = 1'b1;
		while (exp_q.size() != 0 || commit_held != 0) begin
			run_cycle(0, -1, 1'b1, 1'b0);
		end
		run_cycle(0, -1, 1'b0, 1'b0);   // Last credit pulse lands
		check_value("dispatch credits after drain", ROB_DEPTH, disp_credits);
		check_value("dispatch credit sum", retired_count, credit_sum);
	endtask

	// Compare at the falling edge where registered and combinational outputs are settled
	always @(negedge clock) begin : compare
		retire_slot_t exp_row;
		if (rst_n) begin
			for (int k = 0; k < SS_WIDTH; k++) begin
				if (retired[k].valid) begin
					if (k > 0 && !retired[0].valid) begin
						fail_run("Retired slot 1 is valid while slot 0 is empty");
					end else if (exp_q.size() == 0) begin
						fail_run("A row retired that was never dispatched or was flushed");
					end else begin
						exp_row = expected_retire();
						check_value("retired t_new", exp_row.t_new, retired[k].t_new);
						check_value("retired t_old", exp_row.t_old, retired[k].t_old);
						check_value("retired arch_dest", exp_row.arch_dest,
							retired[k].arch_dest);
						check_value("retired op", int'(exp_row.op), int'(retired[k].op));
						retired_count     = retired_count + 1;
						commit_held       = commit_held + 1;
						last_retire_cycle = cycle;
					end
				end
			end
			if (commit_held > COMMIT_CREDITS) begin
				fail_run("More rows retired than the commit credits allowed");
			end
			if (flush) begin
				exp_q.delete();
			end else begin
				credit_sum   = credit_sum + int'(dispatch_credits);
				disp_credits = disp_credits + int'(dispatch_credits);
				if (disp_credits > ROB_DEPTH) begin
					fail_run("Dispatch credits returned beyond the table depth");
				end
			end
		end
	end

	always @(posedge clock) begin
		cycle = cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			fail_run("Timeout, the run did not finish within the cycle limit");
		end
	end

	initial begin
		int base;
		int disp_cycle;
		rst_n         = 1'b0;
		dispatch      = '0;
		cdb           = '0;
		flush         = 1'b0;
		commit_credit = 1'b0;
		repeat (RESET_CYCLES - 1) @(posedge clock);
		@(negedge clock);
		check_value("dispatch_credits in reset", 0, dispatch_credits);
		check_value("retired valid in reset", 0, {retired[1].valid, retired[0].valid});
		@(posedge clock);
		#2;
		rst_n = 1'b1;

		test_name = "store latency";
		base = retired_count;
		run_cycle(1, OP_STORE, 1'b0, 1'b0);
		disp_cycle = cycle;
		while (retired_count == base) begin
			run_cycle(0, -1, 1'b0, 1'b0);
		end
		check_value("cycles from dispatch to retired", 2, last_retire_cycle - disp_cycle);

		// Never broadcast, so these must retire on their own
		test_name = "non-writing ops";
		run_cycle(2, OP_BRANCH, 1'b0, 1'b0);
		run_cycle(2, OP_HALT, 1'b0, 1'b0);
		run_cycle(1, OP_STORE, 1'b0, 1'b0);
		while (exp_q.size() != 0) begin
			run_cycle(0, -1, 1'b0, 1'b0);
		end
		drain();

		test_name = "in-order retirement";
		repeat (RANDOM_CYCLES) run_cycle(-1, -1, 1'b1, 1'b0);
		drain();

		test_name = "commit back-pressure";
		return_enable = 1'b0;
		base = retired_count;
		repeat (3) run_cycle(2, OP_STORE, 1'b0, 1'b0);
		repeat (10) run_cycle(0, -1, 1'b0, 1'b0);
		check_value("rows retired without returns", COMMIT_CREDITS, retired_count - base);
		check_value("rows left waiting", 2, exp_q.size());
		drain();

		test_name = "flush";
		run_cycle(1, OP_STORE, 1'b0, 1'b0);
		repeat (3) run_cycle(2, OP_ALU, 1'b0, 1'b0);
		stale = pending;   // ALU tags still in execution
		run_cycle(0, -1, 1'b0, 1'b1);
		run_cycle(0, -1, 1'b0, 1'b0);
		// Late completions of flushed work must not revive any row
		pending = stale;
		while (pending.size() != 0) begin
			run_cycle(0, -1, 1'b1, 1'b0);
		end
		repeat (4) run_cycle(0, -1, 1'b0, 1'b0);
		repeat (AFTER_FLUSH) run_cycle(-1, -1, 1'b1, 1'b0);
		drain();

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire
